// File: src.f
+incdir+src
src/apb_delay_pkg.sv
src/apb_if.sv
src/apb_delayer.sv
src/apb_mem_target.sv
src/apb_delay_top.sv
dv/apb_delay_assert.sv
dv/apb_delay_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the APB delayer testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert \
  -f src.f \
  --top-module apb_delay_tb \
  -o apb_delay_sim

./obj_dir/apb_delay_sim +verilator+error+limit+100 2>&1 | tee "$LOG"

if grep -qF "** FAIL **" "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi
if ! grep -qF "** PASS **" "$LOG"; then
  echo "simulation ended without a result, see $LOG"
  exit 1
fi
echo "simulation passed"

// File: dv/apb_delay_cases.txt
# op addr data strb prot exp_rdata exp_err, all fields hex
# op W writes and R reads, prot bit 0 marks a privileged access
W 00000000 11223344 f 0 00000000 0
W 00000004 a5a5a5a5 f 0 00000000 0
W 00000008 deadbeef f 0 00000000 0
W 0000001c 0badf00d f 0 00000000 0
R 00000000 00000000 0 0 11223344 0
R 00000004 00000000 0 0 a5a5a5a5 0
R 00000008 00000000 0 0 deadbeef 0
R 0000001c 00000000 0 0 0badf00d 0
W 00000008 cafe1234 3 0 00000000 0
R 00000008 00000000 0 0 dead1234 0
W 00000004 77665544 a 0 00000000 0
R 00000004 00000000 0 0 77a555a5 0
W 00000010 00000000 f 0 00000000 0
W 00000010 ffeeddcc c 0 00000000 0
R 00000010 00000000 0 0 ffee0000 0
W 00000040 12345678 f 1 00000000 1
R 00000044 00000000 0 0 00000000 1
R 00000100 00000000 0 1 00000000 1
R 00000000 00000000 0 0 11223344 0
R 00000004 00000000 0 0 77a555a5 0
W 00000020 01020304 f 1 00000000 0
W 00000020 ffffffff f 0 00000000 1
R 00000020 00000000 0 0 01020304 0
W 00000020 55667788 f 1 00000000 0
R 00000020 00000000 0 0 55667788 0
W 0000003c 99887766 f 2 00000000 1
W 0000003c 99887766 f 3 00000000 0
R 0000003c 00000000 0 0 99887766 0
W 00000018 13579bdf f 0 00000000 0
R 00000018 00000000 0 0 13579bdf 0
R 00000008 00000000 0 0 dead1234 0

// File: dv/apb_delay_tb.sv
`timescale 1ns/1ps
`include "apb_delay_defs.svh"
`default_nettype none

module apb_delay_tb;

  localparam int TIMEOUT     = 500;   // cycles per wait
  localparam     CASE_FILE   = "dv/apb_delay_cases.txt";
  localparam int TGT_CYCLES  = `TGT_WAIT + 2;   // setup, waits, ready
  localparam int BASE_CYCLES = TGT_CYCLES + 2;   // unstretched host transfer
  localparam int PAID_CYCLES = TGT_CYCLES + 1;   // forwarded plus the answer
  localparam int RATIO_INT   = int'(`APB_DELAY_RATIO) >> `APB_DELAY_FRAC_W;

  logic                   clock = 1'b0;
  logic                   reset;
  logic [`APB_ADDR_W-1:0] host_paddr;
  logic                   host_psel;
  logic                   host_penable;
  logic [2:0]             host_pprot;
  logic                   host_pwrite;
  logic [`APB_DATA_W-1:0] host_pwdata;
  logic [`APB_STRB_W-1:0] host_pstrb;
  logic                   host_pready;
  logic [`APB_DATA_W-1:0] host_prdata;
  logic                   host_pslverr;
  integer                 seed = 32'h6b412362;

  always #50 clock = ~clock;

  apb_delay_top u_dut (
    .clock        (clock),
    .reset        (reset),
    .host_paddr   (host_paddr),
    .host_psel    (host_psel),
    .host_penable (host_penable),
    .host_pprot   (host_pprot),
    .host_pwrite  (host_pwrite),
    .host_pwdata  (host_pwdata),
    .host_pstrb   (host_pstrb),
    .host_pready  (host_pready),
    .host_prdata  (host_prdata),
    .host_pslverr (host_pslverr)
  );

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_protocol();
    assert (u_dut.u_assert.assert_fails == 0)
      else report_fail("a bound protocol assertion failed");
  endtask

  // plays one APB transfer as the host and counts setup through ready
  task automatic run_transfer(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input logic [2:0] prot,
                              output logic [31:0] rdata, output logic err, output int cycles);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    rdata  = '0;
    err    = 1'b0;
    @(posedge clock);
    host_paddr   <= addr;
    host_pwrite  <= wr;
    host_pwdata  <= data;
    host_pstrb   <= strb;
    host_pprot   <= prot;
    host_psel    <= 1'b1;
    host_penable <= 1'b0;
    @(posedge clock);
    host_penable <= 1'b1;
    while (!seen) begin
      @(negedge clock);   // outputs settled mid cycle
      waited++;
      check_protocol();
      if (host_pready) begin
        seen  = 1'b1;
        rdata = host_prdata;
        err   = host_pslverr;
      end else if (waited >= TIMEOUT) begin
        report_fail($sformatf("timeout waiting for host_pready at address %h", addr));
      end
    end
    @(posedge clock);
    host_psel    <= 1'b0;
    host_penable <= 1'b0;
    cycles = waited + 1;
  endtask

  initial begin
    int               fd;
    int               code;
    int               n_xfer;
    int               cycles;
    int               gap;
    int               total;
    int               excess;
    int               min_excess;
    logic [7:0]       op_tok;
    logic [8*128-1:0] line;
    logic [31:0]      f_addr;
    logic [31:0]      f_data;
    logic [31:0]      f_strb;
    logic [31:0]      f_prot;
    logic [31:0]      f_rdata;
    logic [31:0]      f_err;
    logic [31:0]      got_rdata;
    logic             got_err;
    logic             done;

    $timeformat(-9, 0, " ns", 0);
    reset        <= 1'b1;
    host_paddr   <= '0;
    host_psel    <= 1'b0;
    host_penable <= 1'b0;
    host_pprot   <= '0;
    host_pwrite  <= 1'b0;
    host_pwdata  <= '0;
    host_pstrb   <= '0;
    repeat (8) @(posedge clock);
    reset <= 1'b0;

    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      report_fail("cannot open the case file");
    end
    n_xfer = 0;
    total  = 0;
    done   = 1'b0;
    while (!done) begin
      code = $fscanf(fd, "%s", op_tok);
      if (code != 1) begin
        done = 1'b1;
      end else if (op_tok == "#") begin
        code = $fgets(line, fd);   // skip comment text
      end else begin
        code = $fscanf(fd, "%h %h %h %h %h %h", f_addr, f_data, f_strb, f_prot, f_rdata, f_err);
        if (code != 6 || (op_tok != "W" && op_tok != "R")) begin
          report_fail($sformatf("malformed line %0d in the case file", n_xfer + 1));
        end
        run_transfer(op_tok == "W", f_addr, f_data, f_strb[3:0], f_prot[2:0],
                     got_rdata, got_err, cycles);
        assert (got_rdata == f_rdata)
          else report_fail($sformatf("ERR %0t: read data at %h is %h, expected %h",
                                     $time, f_addr, got_rdata, f_rdata));
        assert (got_err == f_err[0])
          else report_fail($sformatf("ERR %0t: error at %h is %b, expected %b",
                                     $time, f_addr, got_err, f_err[0]));
        assert (cycles > `TGT_WAIT + 3)
          else report_fail($sformatf("ERR %0t: transfer at %h took only %0d cycles",
                                     $time, f_addr, cycles));
        n_xfer++;
        total += cycles;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(posedge clock);
      end
    end
    $fclose(fd);

    repeat (4) @(posedge clock);
    check_protocol();
    excess     = total - n_xfer * BASE_CYCLES;
    min_excess = RATIO_INT * PAID_CYCLES * n_xfer;
    assert (n_xfer > 0 && excess >= min_excess) begin
      $display("** PASS **");
      $finish;
    end else begin
      report_fail($sformatf("ERR %0t: %0d extra cycles over %0d transfers, expected at least %0d",
                            $time, excess, n_xfer, min_excess));
    end
  end

endmodule

`default_nettype wire

// File: dv/apb_delay_assert.sv
`timescale 1ns/1ps
`include "apb_delay_defs.svh"
`default_nettype none

module apb_delay_assert import apb_delay_pkg::*; (
  input logic                   clock,
  input logic                   reset,
  input logic                   host_psel,
  input logic                   host_pready,
  input logic [`APB_DATA_W-1:0] host_prdata,
  input logic                   psel,
  input logic                   penable,
  input delay_state_e           state
);

  int unsigned assert_fails = 0;   // failed checks so far

  a_pready_pulse: assert property (@(posedge clock) disable iff (reset)
    host_pready |=> !host_pready)
    else begin
      $error("host_pready high for two cycles in a row");
      assert_fails++;
    end

  a_pready_sel: assert property (@(posedge clock) disable iff (reset)
    host_pready |-> host_psel)
    else begin
      $error("host_pready high without host_psel");
      assert_fails++;
    end

  a_rdata_idle: assert property (@(posedge clock) disable iff (reset)
    !host_pready |-> host_prdata == '0)
    else begin
      $error("host_prdata nonzero outside the ready pulse");
      assert_fails++;
    end

  a_enable_sel: assert property (@(posedge clock) disable iff (reset)
    penable |-> psel)
    else begin
      $error("target penable high without psel");
      assert_fails++;
    end

  // target bus released before the delayer goes idle
  a_idle_released: assert property (@(posedge clock) disable iff (reset)
    state == DLY_IDLE |-> !psel && !penable)
    else begin
      $error("target bus still selected while the delayer is idle");
      assert_fails++;
    end

endmodule

bind apb_delay_top apb_delay_assert u_assert (
  .clock       (clock),
  .reset       (reset),
  .host_psel   (host_psel),
  .host_pready (host_pready),
  .host_prdata (host_prdata),
  .psel        (bus.psel),
  .penable     (bus.penable),
  .state       (u_delayer.state)
);

`default_nettype wire

// File: src/apb_delay_top.sv
`timescale 1ns/1ps
`include "apb_delay_defs.svh"
`default_nettype none

module apb_delay_top (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [`APB_ADDR_W-1:0] host_paddr,
  input  logic                   host_psel,
  input  logic                   host_penable,
  input  logic [2:0]             host_pprot,
  input  logic                   host_pwrite,
  input  logic [`APB_DATA_W-1:0] host_pwdata,
  input  logic [`APB_STRB_W-1:0] host_pstrb,
  output logic                   host_pready,
  output logic [`APB_DATA_W-1:0] host_prdata,
  output logic                   host_pslverr
);

  apb_if bus ();   // delayer to target

  apb_delayer u_delayer (
    .clock        (clock),
    .reset        (reset),
    .host_paddr   (host_paddr),
    .host_psel    (host_psel),
    .host_penable (host_penable),
    .host_pprot   (host_pprot),
    .host_pwrite  (host_pwrite),
    .host_pwdata  (host_pwdata),
    .host_pstrb   (host_pstrb),
    .host_pready  (host_pready),
    .host_prdata  (host_prdata),
    .host_pslverr (host_pslverr),
    .bus          (bus.requester)
  );

  apb_mem_target u_target (
    .clock (clock),
    .reset (reset),
    .bus   (bus.completer)
  );

endmodule

`default_nettype wire

// File: src/apb_mem_target.sv
`timescale 1ns/1ps
`include "apb_delay_defs.svh"
`default_nettype none

module apb_mem_target import apb_delay_pkg::*; (
  input logic      clock,
  input logic      reset,
  apb_if.completer bus
);

  localparam int OFF_W  = $clog2(`APB_STRB_W);
  localparam int IDX_W  = $clog2(`TGT_DEPTH);
  localparam int WA_W   = `APB_ADDR_W - OFF_W;
  localparam int WAIT_W = 8;

  logic [`APB_DATA_W-1:0] mem [`TGT_DEPTH];
  logic [WA_W-1:0]        word_addr;
  logic [IDX_W-1:0]       idx;
  logic [WAIT_W-1:0]      wait_cnt;
  logic                   access;
  logic                   ready;
  logic                   in_range;
  logic                   upper_half;
  tgt_resp_e              resp;

  assign word_addr  = bus.paddr[`APB_ADDR_W-1:OFF_W];
  assign idx        = word_addr[IDX_W-1:0];
  assign in_range   = word_addr < WA_W'(`TGT_DEPTH);
  assign upper_half = idx[IDX_W-1];
  assign access     = bus.psel && bus.penable;
  assign ready      = access && (wait_cnt == WAIT_W'(`TGT_WAIT));

  always_comb begin
    if (!in_range) begin
      resp = TGT_RANGE_ERR;
    end else if (bus.pwrite && upper_half && !bus.pprot[0]) begin
      resp = TGT_PROT_ERR;   // unprivileged write
    end else begin
      resp = TGT_OKAY;
    end
  end

  // counts enable cycles of the current access
  always_ff @(posedge clock) begin
    if (reset) begin
      wait_cnt <= '0;
    end else if (!access || ready) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // byte merge under strobe, only on an okay write
  always_ff @(posedge clock) begin
    if (ready && bus.pwrite && resp == TGT_OKAY) begin
      for (int b = 0; b < `APB_STRB_W; b++) begin
        if (bus.pstrb[b]) begin
          mem[idx][8*b +: 8] <= bus.pwdata[8*b +: 8];
        end
      end
    end
  end

  assign bus.pready  = ready;
  assign bus.pslverr = ready && (resp != TGT_OKAY);
  assign bus.prdata  = (ready && !bus.pwrite && resp == TGT_OKAY) ? mem[idx] : '0;

endmodule

`default_nettype wire

// File: src/apb_delayer.sv
`timescale 1ns/1ps
`include "apb_delay_defs.svh"
`default_nettype none

module apb_delayer import apb_delay_pkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [`APB_ADDR_W-1:0] host_paddr,
  input  logic                   host_psel,
  input  logic                   host_penable,
  input  logic [2:0]             host_pprot,
  input  logic                   host_pwrite,
  input  logic [`APB_DATA_W-1:0] host_pwdata,
  input  logic [`APB_STRB_W-1:0] host_pstrb,
  output logic                   host_pready,
  output logic [`APB_DATA_W-1:0] host_prdata,
  output logic                   host_pslverr,
  apb_if.requester               bus
);

  localparam int ACC_W = 16;
  localparam int INT_W = ACC_W - `APB_DELAY_FRAC_W;
  localparam logic [ACC_W-1:0] RATIO = `APB_DELAY_RATIO;

  delay_state_e           state;
  delay_state_e           resume_state;  // target of hold once drained
  logic [ACC_W-1:0]       acc;
  logic [ACC_W-1:0]       acc_add;
  logic [INT_W-1:0]       acc_int;
  logic                   psel_q;
  logic                   penable_q;
  logic                   pready_q;
  logic [`APB_DATA_W-1:0] prdata_q;
  logic                   pslverr_q;
  logic                   capture;

  assign acc_add = acc + RATIO;
  assign acc_int = acc[ACC_W-1 -: INT_W];
  assign capture = (state == DLY_ENABLE) && penable_q && bus.pready;

  // request fields go straight through
  assign bus.paddr   = host_paddr;
  assign bus.pprot   = host_pprot;
  assign bus.pwrite  = host_pwrite;
  assign bus.pwdata  = host_pwdata;
  assign bus.pstrb   = host_pstrb;
  assign bus.psel    = psel_q;
  assign bus.penable = penable_q;

  assign host_pready  = pready_q;
  assign host_prdata  = pready_q ? prdata_q : '0;
  assign host_pslverr = pready_q & pslverr_q;

  // response held until the host pulse
  always_ff @(posedge clock) begin
    if (capture) begin
      prdata_q  <= bus.prdata;
      pslverr_q <= bus.pslverr;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= DLY_IDLE;
      resume_state <= DLY_IDLE;
      acc          <= '0;
      psel_q       <= 1'b0;
      penable_q    <= 1'b0;
      pready_q     <= 1'b0;
    end else begin
      case (state)
        DLY_IDLE: begin
          psel_q    <= 1'b0;
          penable_q <= 1'b0;
          pready_q  <= 1'b0;
          if (host_psel) begin
            acc          <= acc_add;
            state        <= DLY_HOLD;
            resume_state <= DLY_SELECT;
          end
        end
        DLY_SELECT: begin
          psel_q <= 1'b1;   // setup cycle on the target bus
          acc    <= acc_add;
          if (host_penable) begin
            state <= DLY_ENABLE;
          end
        end
        DLY_ENABLE: begin
          penable_q <= 1'b1;
          acc       <= acc_add;
          if (capture) begin
            // target done so release its bus
            psel_q       <= 1'b0;
            penable_q    <= 1'b0;
            state        <= DLY_HOLD;
            resume_state <= DLY_RESPOND;
          end
        end
        DLY_RESPOND: begin
          pready_q     <= 1'b1;
          acc          <= acc_add;
          state        <= DLY_HOLD;
          resume_state <= DLY_IDLE;
        end
        DLY_HOLD: begin
          pready_q <= 1'b0;   // one cycle pulse
          if (acc_int == '0) begin
            state <= resume_state;
          end else begin
            acc[ACC_W-1 -: INT_W] <= acc_int - 1'b1;   // fraction kept
          end
        end
        default: begin
          state        <= DLY_IDLE;
          resume_state <= DLY_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/apb_if.sv
`timescale 1ns/1ps
`include "apb_delay_defs.svh"
`default_nettype none

interface apb_if;

  logic [`APB_ADDR_W-1:0] paddr;
  logic                   psel;
  logic                   penable;
  logic [2:0]             pprot;
  logic                   pwrite;
  logic [`APB_DATA_W-1:0] pwdata;
  logic [`APB_STRB_W-1:0] pstrb;
  logic                   pready;
  logic [`APB_DATA_W-1:0] prdata;
  logic                   pslverr;

  modport requester (
    output paddr, psel, penable, pprot, pwrite, pwdata, pstrb,
    input  pready, prdata, pslverr
  );

  modport completer (
    input  paddr, psel, penable, pprot, pwrite, pwdata, pstrb,
    output pready, prdata, pslverr
  );

endinterface

`default_nettype wire

// File: src/apb_delay_pkg.sv
`default_nettype none

package apb_delay_pkg;

  // delayer FSM where hold drains the accumulator's integer part
  typedef enum logic [2:0] {
    DLY_IDLE,
    DLY_SELECT,
    DLY_ENABLE,
    DLY_RESPOND,
    DLY_HOLD
  } delay_state_e;

  // target outcome; anything but okay raises pslverr with zero read data
  typedef enum logic [1:0] {
    TGT_OKAY,
    TGT_RANGE_ERR,   // word index beyond depth
    TGT_PROT_ERR     // upper half write without privileged prot
  } tgt_resp_e;

endpackage

`default_nettype wire

// File: src/apb_delay_defs.svh
`ifndef APB_DELAY_DEFS_SVH
`define APB_DELAY_DEFS_SVH

// apb bus widths
`define APB_ADDR_W 32
`define APB_DATA_W 32
`define APB_STRB_W 4

// delay ratio in 12.4 fixed point
// 2.625 = 2 + 0.5 + 0.125 -> 16'h002a
`define APB_DELAY_RATIO 16'h002a
`define APB_DELAY_FRAC_W 4

// register target
`define TGT_DEPTH 16
`define TGT_WAIT 1   // enable cycles before pready

`endif
